//--- source/phold_pkg.sv
`default_nettype none

package phold_pkg;

   // logical process id, 64 processes
   localparam int LP_W = 6;

   // event timestamp
   localparam int TIME_W = 16;

   // statistic counters
   localparam int CNT_W = 32;

   // one scheduled event, 23 bits
   typedef struct packed {
      logic              is_anti;
      logic [LP_W-1:0]   lp;
      logic [TIME_W-1:0] ts;
   } event_t;

   // run phases of the scheduler
   typedef enum logic [2:0] {
      RS_IDLE     = 3'd0,
      RS_INIT     = 3'd1,
      RS_READY    = 3'd2,
      RS_RUNNING  = 3'd3,
      RS_FINISHED = 3'd4
   } run_state_t;

endpackage

`default_nettype wire

//--- source/run_control.sv
`timescale 1ns/10ps
`default_nettype none

module run_control
   import phold_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic [TIME_W-1:0] sim_end,
   input  wire logic              init_done,
   input  wire logic [TIME_W-1:0] gvt,
   output run_state_t             state,
   output logic                   rtn_vld,
   output logic [CNT_W-1:0]       total_cycles
);

   run_state_t state_nxt;
   logic       sim_over;

   // end of simulation once gvt passes the configured limit
   assign sim_over = (gvt > sim_end);

   always_comb begin
      state_nxt = state;
      case (state)
         RS_IDLE: begin
            state_nxt = RS_INIT;
         end
         RS_INIT: begin
            if (init_done) begin
               state_nxt = RS_READY;
            end
         end
         RS_READY: begin
            state_nxt = RS_RUNNING;
         end
         RS_RUNNING: begin
            if (sim_over) begin
               state_nxt = RS_FINISHED;
            end
         end
         // finished is held until the next reset
         RS_FINISHED: begin
            state_nxt = RS_FINISHED;
         end
         default: begin
            state_nxt = RS_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= RS_IDLE;
         rtn_vld <= 1'b0;
      end else begin
         state   <= state_nxt;
         // single pulse on the way into finished
         rtn_vld <= (state == RS_RUNNING) && sim_over;
      end
   end

   // cycles spent running
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_cycles <= '0;
      end else if (state == RS_RUNNING) begin
         total_cycles <= total_cycles + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/event_intake.sv
`timescale 1ns/10ps
`default_nettype none

module event_intake
   import phold_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire run_state_t      state,
   input  wire logic [7:0]      num_init_events,
   input  wire logic [LP_W-1:0] lp_mask,
   input  wire logic            ret_vld,
   input  wire event_t          ret_evt,
   input  wire logic            push_ack,
   output logic                 ret_ack,
   output logic                 push_req,
   output event_t               push_evt,
   output logic                 init_done
);

   logic   [7:0] init_cnt;
   logic         in_init;
   logic         in_run;
   logic         ret_null;
   logic         init_last;
   event_t       init_evt;

   assign in_init = (state == RS_INIT);
   assign in_run  = (state == RS_RUNNING);

   // null message: anti flag with lp and ts both zero
   assign ret_null = ret_evt.is_anti && (ret_evt.lp == '0) && (ret_evt.ts == '0);

   // initial event i goes to lp (i & lp_mask) at time 0
   assign init_evt.is_anti = 1'b0;
   assign init_evt.lp      = init_cnt[LP_W-1:0] & lp_mask;
   assign init_evt.ts      = '0;

   assign init_last = (init_cnt + 8'd1 == num_init_events);

   assign push_req = (in_init && (init_cnt < num_init_events)) ||
                     (in_run && ret_vld && !ret_null);
   assign push_evt = in_init ? init_evt : ret_evt;

   // nulls are taken at once, real events only with the queue's ack
   assign ret_ack = in_run && ret_vld && (ret_null || push_ack);

   assign init_done = in_init && ((push_ack && init_last) || (num_init_events == 8'd0));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_cnt <= '0;
      end else if (!in_init) begin
         init_cnt <= '0;
      end else if (push_ack) begin
         init_cnt <= init_cnt + 8'd1;
      end
   end

endmodule

`default_nettype wire

//--- source/event_queue.sv
`timescale 1ns/10ps
`default_nettype none

module event_queue
   import phold_pkg::*;
#(
   parameter int QUEUE_DEPTH = 16
) (
   input  wire logic   clk,
   input  wire logic   rst_n,
   input  wire logic   push_req,
   input  wire event_t push_evt,
   input  wire logic   pop_req,
   output logic        push_ack,
   output logic        pop_ack,
   output event_t      head,
   output logic        empty,
   output logic        full
);

   event_t                 entry [QUEUE_DEPTH];
   event_t                 shift_src [QUEUE_DEPTH];
   event_t                 pop_src [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] vld;
   logic [QUEUE_DEPTH-1:0] keep;
   logic [TIME_W:0]        new_key;
   logic                   busy;

   // sort key: ts first, anti-messages ahead of positive ones at equal ts
   function automatic logic [TIME_W:0] sort_key(input event_t e);
      sort_key = {e.ts, ~e.is_anti};
   endfunction

   assign new_key = sort_key(push_evt);

   // one operation per two cycles, push has priority
   assign push_ack = push_req && !busy && !full;
   assign pop_ack  = pop_req && !busy && !empty && !push_ack;

   assign head  = entry[0];
   assign empty = !vld[0];
   assign full  = vld[QUEUE_DEPTH-1];

   for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_entry
      // equal keys stay ahead of the newcomer
      assign keep[i] = vld[i] && (sort_key(entry[i]) <= new_key);

      if (i == 0) begin : g_first
         assign shift_src[i] = push_evt;
      end else begin : g_shift
         // newcomer lands right after the last kept entry
         assign shift_src[i] = keep[i-1] ? push_evt : entry[i-1];
      end

      if (i == QUEUE_DEPTH - 1) begin : g_last
         assign pop_src[i] = entry[i];
      end else begin : g_pull
         assign pop_src[i] = entry[i+1];
      end

      always_ff @(posedge clk) begin
         if (push_ack) begin
            // insert at the first slot past the kept ones, shift the rest up
            if (!keep[i]) begin
               entry[i] <= shift_src[i];
            end
         end else if (pop_ack) begin
            entry[i] <= pop_src[i];
         end
      end
   end

   // occupancy as a thermometer code
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld  <= '0;
         busy <= 1'b0;
      end else begin
         busy <= push_ack || pop_ack;
         if (push_ack) begin
            vld <= {vld[QUEUE_DEPTH-2:0], 1'b1};
         end else if (pop_ack) begin
            vld <= {1'b0, vld[QUEUE_DEPTH-1:1]};
         end
      end
   end

endmodule

`default_nettype wire

//--- source/event_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module event_dispatch
   import phold_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire run_state_t  state,
   input  wire logic        disp_ready,
   input  wire logic        pop_ack,
   input  wire event_t      head,
   input  wire logic        empty,
   output logic             pop_req,
   output logic             disp_vld,
   output event_t           disp_evt,
   output logic [TIME_W-1:0] gvt,
   output logic [CNT_W-1:0] total_events,
   output logic [CNT_W-1:0] total_antimsg
);

   logic gvt_raise;

   // ask only while running and some core can take an event
   assign pop_req = (state == RS_RUNNING) && disp_ready && !empty;

   // anti-messages never move gvt forward
   assign gvt_raise = pop_ack && !head.is_anti && (head.ts > gvt);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         disp_vld <= 1'b0;
      end else begin
         disp_vld <= pop_ack;
      end
   end

   // popped head, valid with disp_vld
   always_ff @(posedge clk) begin
      if (pop_ack) begin
         disp_evt <= head;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (gvt_raise) begin
         gvt <= head.ts;
      end
   end

   // dispatch statistics
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_events  <= '0;
         total_antimsg <= '0;
      end else if (pop_ack) begin
         total_events <= total_events + 1'b1;
         if (head.is_anti) begin
            total_antimsg <= total_antimsg + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/phold_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module phold_scheduler
   import phold_pkg::*;
#(
   parameter int QUEUE_DEPTH = 16
) (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic [TIME_W-1:0] sim_end,
   input  wire logic [7:0]        num_init_events,
   input  wire logic [LP_W-1:0]   lp_mask,
   input  wire logic              ret_vld,
   input  wire event_t            ret_evt,
   output logic                   ret_ack,
   input  wire logic              disp_ready,
   output logic                   disp_vld,
   output event_t                 disp_evt,
   output logic [TIME_W-1:0]      gvt,
   output logic                   rtn_vld,
   output logic [CNT_W-1:0]       total_cycles,
   output logic [CNT_W-1:0]       total_events,
   output logic [CNT_W-1:0]       total_antimsg
);

   run_state_t state;
   logic       init_done;
   logic       push_req;
   event_t     push_evt;
   logic       push_ack;
   logic       pop_req;
   logic       pop_ack;
   event_t     head;
   logic       empty;

   run_control run_control_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .sim_end      (sim_end),
      .init_done    (init_done),
      .gvt          (gvt),
      .state        (state),
      .rtn_vld      (rtn_vld),
      .total_cycles (total_cycles)
   );

   // producer side of the queue
   event_intake event_intake_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .state           (state),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .ret_vld         (ret_vld),
      .ret_evt         (ret_evt),
      .push_ack        (push_ack),
      .ret_ack         (ret_ack),
      .push_req        (push_req),
      .push_evt        (push_evt),
      .init_done       (init_done)
   );

   event_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) event_queue_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .push_req (push_req),
      .push_evt (push_evt),
      .pop_req  (pop_req),
      .push_ack (push_ack),
      .pop_ack  (pop_ack),
      .head     (head),
      .empty    (empty),
      .full     ()
   );

   // consumer side, toward the cores
   event_dispatch event_dispatch_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .state         (state),
      .disp_ready    (disp_ready),
      .pop_ack       (pop_ack),
      .head          (head),
      .empty         (empty),
      .pop_req       (pop_req),
      .disp_vld      (disp_vld),
      .disp_evt      (disp_evt),
      .gvt           (gvt),
      .total_events  (total_events),
      .total_antimsg (total_antimsg)
   );

endmodule

`default_nettype wire

//--- verif/phold_scheduler_checker.sv
`timescale 1ns/10ps
`default_nettype none

module phold_scheduler_checker (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic push_ack,
   input wire logic pop_ack,
   input wire logic disp_vld,
   input wire logic rtn_vld
);

   logic any_ack;

   assign any_ack = push_ack || pop_ack;

   // queue serves one side per operation
   a_one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(push_ack && pop_ack))
      else $error("push_ack and pop_ack high in the same cycle");

   // busy cycle after every operation
   a_busy: assert property (@(posedge clk) disable iff (!rst_n) any_ack |=> !any_ack)
      else $error("queue acknowledged two cycles in a row");

   a_disp_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
                                      disp_vld |-> $past(pop_ack))
      else $error("disp_vld without pop_ack on the cycle before");

   a_rtn_pulse: assert property (@(posedge clk) disable iff (!rst_n) rtn_vld |=> !rtn_vld)
      else $error("rtn_vld high for two cycles");

endmodule

`default_nettype wire

//--- verif/phold_scheduler_tb.sv
`timescale 1ns/10ps
`default_nettype none

module phold_scheduler_tb
   import phold_pkg::*;
();

   localparam int    QUEUE_DEPTH  = 16;
   localparam int    CLK_PERIOD   = 40;
   localparam int    RESET_CYCLES = 10;
   localparam int    STALL_CYCLES = 12;
   localparam int    POST_CYCLES  = 20;
   localparam string DATA_FILE    = "verif/phold_testdata.txt";

   logic              clk;
   logic              rst_n;
   logic [TIME_W-1:0] sim_end;
   logic [7:0]        num_init_events;
   logic [LP_W-1:0]   lp_mask;
   logic              ret_vld;
   event_t            ret_evt;
   logic              ret_ack;
   logic              disp_ready;
   logic              disp_vld;
   event_t            disp_evt;
   logic [TIME_W-1:0] gvt;
   logic              rtn_vld;
   logic [CNT_W-1:0]  total_cycles;
   logic [CNT_W-1:0]  total_events;
   logic [CNT_W-1:0]  total_antimsg;

   integer            seed;
   logic [31:0]       rnd;
   event_t            rec_q[$];
   event_t            model_q[$];
   event_t            exp_evt;
   bit [TIME_W-1:0]   model_gvt;
   int                model_events;
   int                model_anti;
   int                num_records;
   int                post_cnt;
   bit                dispatch_on;
   bit                lifted;
   bit                lift_now;
   bit                rtn_due;
   bit                finished;
   bit                ready_prev;
   bit                run_over;

   phold_scheduler #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) phold_scheduler_i (.*);

   bind phold_scheduler phold_scheduler_checker checker_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .push_ack (push_ack),
      .pop_ack  (pop_ack),
      .disp_vld (disp_vld),
      .rtn_vld  (rtn_vld)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error: %s expected %0h actual %0h", name, expected, actual);
         stop_with_failure();
      end
   endtask

   // null message: anti flag, lp 0, ts 0
   function automatic bit is_null_msg(input event_t ev);
      return ev.is_anti && (ev.lp == 0) && (ev.ts == 0);
   endfunction

   function automatic bit goes_before(input event_t a, input event_t b);
      if (a.ts != b.ts) begin
         return a.ts < b.ts;
      end
      return a.is_anti && !b.is_anti;
   endfunction

   // stable insert, equal keys stay behind earlier arrivals
   task automatic model_insert(input event_t ev);
      int pos;
      pos = 0;
      while (pos < model_q.size() && !goes_before(ev, model_q[pos])) pos++;
      model_q.insert(pos, ev);
   endtask

   task automatic load_testdata();
      int     fd;
      int     n;
      int     a;
      int     b;
      int     c;
      bit     have_cfg;
      string  line;
      event_t ev;
      have_cfg = 0;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the test data file %s", DATA_FILE);
         stop_with_failure();
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%d %d %d", a, b, c);
            if (n != 3) begin
               $display("malformed test data line: %s", line);
               stop_with_failure();
            end else if (!have_cfg) begin
               num_init_events = 8'(a);
               lp_mask         = LP_W'(b);
               sim_end         = TIME_W'(c);
               have_cfg        = 1;
            end else begin
               ev.ts      = TIME_W'(a);
               ev.lp      = LP_W'(b);
               ev.is_anti = (c != 0);
               rec_q.push_back(ev);
            end
         end
      end
      $fclose(fd);
      if (rec_q.size() == 0) begin
         $display("the test data file holds no returned events");
         stop_with_failure();
      end
      num_records = rec_q.size();
   endtask

   task automatic deliver_returns();
      bit null_msg;
      foreach (rec_q[k]) begin
         null_msg = is_null_msg(rec_q[k]);
         @(posedge clk);
         ret_vld <= 1'b1;
         ret_evt <= rec_q[k];
         // queue already full, this one has to wait for the first dispatch
         if (!null_msg && !dispatch_on && model_q.size() >= QUEUE_DEPTH) begin
            repeat (STALL_CYCLES) begin
               @(negedge clk);
               check_value("ret_ack while queue full", 0, ret_ack);
            end
            dispatch_on = 1'b1;
         end
         @(negedge clk);
         if (null_msg) begin
            check_value("null message ret_ack", 1, ret_ack);
         end
         while (!ret_ack) @(negedge clk);
      end
      @(posedge clk);
      ret_vld <= 1'b0;
   endtask

   // random ready once dispatching is allowed
   always @(posedge clk) begin
      if (dispatch_on) begin
         rnd = $random(seed);
         disp_ready <= rnd[0];
      end
   end

   // model and checks, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         lift_now = 0;
         check_value("rtn_vld", rtn_due, rtn_vld);
         if (rtn_vld) begin
            check_value("total_events", model_events, total_events);
            check_value("total_antimsg", model_anti, total_antimsg);
            check_value("total_cycles nonzero", 1, total_cycles != 0);
            finished = 1;
         end
         if (!dispatch_on || finished) begin
            check_value("disp_vld while held or finished", 0, disp_vld);
         end
         if (disp_vld) begin
            check_value("disp_ready before disp_vld", 1, ready_prev);
            if (model_q.size() == 0) begin
               $display("an event was dispatched that the model does not hold");
               stop_with_failure();
            end
            exp_evt = model_q.pop_front();
            check_value("disp_evt", exp_evt, disp_evt);
            model_events++;
            if (exp_evt.is_anti) begin
               model_anti++;
            end else if (exp_evt.ts > model_gvt) begin
               model_gvt = exp_evt.ts;
            end
            if (!lifted && model_gvt > sim_end) begin
               lifted   = 1;
               lift_now = 1;
            end
         end
         check_value("gvt", model_gvt, gvt);
         if (ret_vld && ret_ack && !is_null_msg(ret_evt)) begin
            model_insert(ret_evt);
         end
         rtn_due    = lift_now;
         ready_prev = disp_ready;
         if (finished) begin
            post_cnt++;
            run_over = (post_cnt >= POST_CYCLES);
         end
      end
   end

   initial begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      ret_vld         = 1'b0;
      ret_evt         = '0;
      disp_ready      = 1'b0;
      sim_end         = '0;
      num_init_events = '0;
      lp_mask         = '0;
      seed            = 32'h307ec474;
      load_testdata();
      // initial events enter the queue first, in index order
      for (int i = 0; i < num_init_events; i++) begin
         model_insert('{is_anti: 1'b0, lp: LP_W'(i) & lp_mask, ts: '0});
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      deliver_returns();
      dispatch_on = 1'b1;
      wait (run_over);
      $display("Everything OK");
      $finish;
   end

   initial begin
      wait (num_records > 0);
      #((RESET_CYCLES + 4 * num_records + 8 * QUEUE_DEPTH + 50) * CLK_PERIOD);
      $display("timeout: the run did not reach its end in time");
      stop_with_failure();
   end

endmodule

`default_nettype wire

//--- verif/phold_testdata.txt
# first data line: num_init_events lp_mask sim_end, all decimal
# other lines, one returned event each: ts lp is_anti (0 0 1 is a null message)
6 5 20
20 7 0
12 9 0
12 2 1
30 11 0
12 14 0
0 0 1
8 21 0
25 33 1
8 40 0
45 50 0
12 3 1
5 60 0

//--- all.f
source/phold_pkg.sv
source/run_control.sv
source/event_intake.sv
source/event_queue.sv
source/event_dispatch.sv
source/phold_scheduler.sv
verif/phold_scheduler_checker.sv
verif/phold_scheduler_tb.sv

//--- Makefile
# Verilator build and run of the scheduler testbench

VERILATOR ?= verilator
TOP       ?= phold_scheduler_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SOURCES := $(wildcard source/*.sv verif/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
